//--- design/ooo_cfg_pkg.sv
package ooo_cfg_pkg;

  // architectural register file
  localparam int NUM_REGS  = 16;
  localparam int REG_IDX_W = 4;   // index into the register file
  localparam int DATA_W    = 16;  // register and result width

  // reorder buffer, its index doubles as the rename tag
  localparam int ROB_DEPTH = 8;
  localparam int TAG_W     = $clog2(ROB_DEPTH);

  // instruction word
  localparam int OPC_W     = 4;

  // defaults for the top level depth parameters
  localparam int IQ_DEPTH_DEF = 4;
  localparam int RS_DEPTH_DEF = 4;

endpackage

//--- design/ooo_types_pkg.sv
package ooo_types_pkg;

  import ooo_cfg_pkg::*;

  // 16 bit instruction word, opcode in the top nibble
  typedef struct packed {
    logic [OPC_W-1:0]     opcode;
    logic [REG_IDX_W-1:0] rd;
    logic [REG_IDX_W-1:0] rs1;
    logic [REG_IDX_W-1:0] rs2;
  } instr_t;

  // value when known, else the producer tag in the low TAG_W bits
  typedef struct packed {
    logic              known;
    logic [DATA_W-1:0] data;
  } operand_t;

  typedef struct packed {
    logic [OPC_W-1:0] opcode;
    logic [TAG_W-1:0] tag;    // reorder buffer slot of this op
    operand_t         src1;
    operand_t         src2;
  } dispatch_t;

  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [OPC_W-1:0]  opcode;
    logic [DATA_W-1:0] src1;
    logic [DATA_W-1:0] src2;
    logic              unit;  // 0 for station a, 1 for station b
  } issue_op_t;

  typedef struct packed {
    logic              valid;
    logic [TAG_W-1:0]  tag;
    logic [DATA_W-1:0] value;
  } cdb_t;

  typedef struct packed {
    logic                 valid;
    logic [REG_IDX_W-1:0] rd;
    logic [TAG_W-1:0]     tag;
    logic [DATA_W-1:0]    value;
  } retire_t;

  typedef struct packed {
    logic                 valid;
    logic [REG_IDX_W-1:0] rd;
  } rob_alloc_t;

endpackage

//--- design/instr_queue.sv
`timescale 1ns/1ps

module instr_queue import ooo_types_pkg::*; #(
  parameter int iq_depth = 4
) (
  input  logic   run,
  input  logic   arst_n,
  input  logic   instr_valid,
  input  instr_t instr,
  output logic   instr_ready,
  output logic   iq_valid,
  output instr_t iq_instr,
  input  logic   iq_ready
);

  localparam int PTR_W = (iq_depth > 1) ? $clog2(iq_depth) : 1;
  localparam int CNT_W = $clog2(iq_depth + 1);

  instr_t           mem [iq_depth];
  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // wrap for depths that are not a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(iq_depth - 1))
      return '0;
    return p + 1'b1;
  endfunction

  assign iq_valid    = (count != '0);
  assign iq_instr    = mem[head];
  assign pop         = iq_valid && iq_ready;
  // full queue still takes a new word when the head leaves this cycle
  assign instr_ready = (count != CNT_W'(iq_depth)) || pop;
  assign push        = instr_valid && instr_ready;

  always_ff @(posedge run)
  begin
    if (push)
      mem[tail] <= instr;
  end

  always_ff @(posedge run or negedge arst_n)
  begin
    if (!arst_n)
    begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        tail <= ptr_next(tail);
      if (pop)
        head <= ptr_next(head);
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

endmodule

//--- design/rename_dispatch.sv
`timescale 1ns/1ps

module rename_dispatch import ooo_cfg_pkg::*; import ooo_types_pkg::*; (
  input  logic              run,
  input  logic              arst_n,
  input  logic              iq_valid,
  input  instr_t            iq_instr,
  output logic              iq_ready,
  input  logic              rob_full,
  input  logic [TAG_W-1:0]  alloc_tag,
  output rob_alloc_t        rob_alloc,
  output logic [TAG_W-1:0]  rd_tag_a,
  output logic [TAG_W-1:0]  rd_tag_b,
  input  logic              rd_done_a,
  input  logic              rd_done_b,
  input  logic [DATA_W-1:0] rd_value_a,
  input  logic [DATA_W-1:0] rd_value_b,
  input  logic              rs_a_full,
  input  logic              rs_b_full,
  output dispatch_t         disp,
  output logic              disp_a_we,
  output logic              disp_b_we,
  input  cdb_t              cdb,
  input  retire_t           retire
);

  logic [DATA_W-1:0] regs      [NUM_REGS];
  logic              map_valid [NUM_REGS];  // register renamed to an in-flight tag
  logic [TAG_W-1:0]  map_tag   [NUM_REGS];
  logic              to_a;
  logic              to_b;
  logic              discard;
  logic              fire;
  logic              alloc;

  // cdb forward, then finished rob entry, then register file, else wait on tag
  function automatic operand_t build_operand(input logic              mapped,
                                             input logic [TAG_W-1:0]  tag,
                                             input logic [DATA_W-1:0] reg_value,
                                             input logic              done,
                                             input logic [DATA_W-1:0] rob_value,
                                             input cdb_t              bus);
    operand_t op;
    op.known = 1'b1;
    if (mapped && bus.valid && bus.tag == tag)
      op.data = bus.value;
    else if (mapped && done)
      op.data = rob_value;
    else if (!mapped)
      op.data = reg_value;
    else
    begin
      op.known = 1'b0;
      op.data  = DATA_W'(tag);
    end
    return op;
  endfunction

  always_comb
  begin
    to_a = 1'b0;
    to_b = 1'b0;
    case (iq_instr.opcode)
      4'd0, 4'd1: to_a = 1'b1;
      4'd2, 4'd3: to_b = 1'b1;
      default: ;  // unknown opcode, dropped at the head
    endcase
  end

  assign discard  = !(to_a || to_b);
  assign iq_ready = discard || (!rob_full && ((to_a && !rs_a_full) || (to_b && !rs_b_full)));
  assign fire     = iq_valid && iq_ready;
  assign alloc    = fire && !discard;

  assign rd_tag_a = map_tag[iq_instr.rs1];
  assign rd_tag_b = map_tag[iq_instr.rs2];

  assign rob_alloc.valid = alloc;
  assign rob_alloc.rd    = iq_instr.rd;

  assign disp.opcode = iq_instr.opcode;
  assign disp.tag    = alloc_tag;
  assign disp.src1   = build_operand(map_valid[iq_instr.rs1], rd_tag_a, regs[iq_instr.rs1],
                                     rd_done_a, rd_value_a, cdb);
  assign disp.src2   = build_operand(map_valid[iq_instr.rs2], rd_tag_b, regs[iq_instr.rs2],
                                     rd_done_b, rd_value_b, cdb);
  assign disp_a_we   = alloc && to_a;
  assign disp_b_we   = alloc && to_b;

  always_ff @(posedge run or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < NUM_REGS; i++)
      begin
        regs[i]      <= '0;
        map_valid[i] <= 1'b0;
        map_tag[i]   <= '0;
      end
    end
    else
    begin
      if (retire.valid)
      begin
        regs[retire.rd] <= retire.value;
        if (map_valid[retire.rd] && map_tag[retire.rd] == retire.tag)
          map_valid[retire.rd] <= 1'b0;  // no younger writer left
      end
      // a rename in the same cycle wins over the clear above
      if (alloc)
      begin
        map_valid[iq_instr.rd] <= 1'b1;
        map_tag[iq_instr.rd]   <= alloc_tag;
      end
    end
  end

endmodule

//--- design/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer import ooo_cfg_pkg::*; import ooo_types_pkg::*; (
  input  logic              run,
  input  logic              arst_n,
  input  rob_alloc_t        rob_alloc,
  output logic [TAG_W-1:0]  alloc_tag,
  output logic              rob_full,
  input  logic [TAG_W-1:0]  rd_tag_a,
  input  logic [TAG_W-1:0]  rd_tag_b,
  output logic              rd_done_a,
  output logic              rd_done_b,
  output logic [DATA_W-1:0] rd_value_a,
  output logic [DATA_W-1:0] rd_value_b,
  input  cdb_t              cdb,
  output retire_t           retire
);

  localparam int CNT_W = TAG_W + 1;

  logic [REG_IDX_W-1:0] ent_rd    [ROB_DEPTH];
  logic [DATA_W-1:0]    ent_value [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] ent_done;
  logic [TAG_W-1:0]     head;  // oldest op, next to retire
  logic [TAG_W-1:0]     tail;  // next free slot
  logic [CNT_W-1:0]     count;
  logic                 do_retire;

  assign alloc_tag = tail;
  assign rob_full  = (count == CNT_W'(ROB_DEPTH));

  // operand read port for dispatch
  assign rd_done_a  = ent_done[rd_tag_a];
  assign rd_done_b  = ent_done[rd_tag_b];
  assign rd_value_a = ent_value[rd_tag_a];
  assign rd_value_b = ent_value[rd_tag_b];

  assign do_retire = (count != '0) && ent_done[head];

  always_comb
  begin
    retire.valid = do_retire;
    retire.rd    = ent_rd[head];
    retire.tag   = head;
    retire.value = ent_value[head];
  end

  always_ff @(posedge run)
  begin
    if (rob_alloc.valid)
      ent_rd[tail] <= rob_alloc.rd;
    if (cdb.valid)
      ent_value[cdb.tag] <= cdb.value;
  end

  always_ff @(posedge run or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ent_done <= '0;
      head     <= '0;
      tail     <= '0;
      count    <= '0;
    end
    else
    begin
      if (rob_alloc.valid)
      begin
        ent_done[tail] <= 1'b0;
        tail           <= tail + 1'b1;
      end
      if (cdb.valid)
        ent_done[cdb.tag] <= 1'b1;  // result captured, head may retire next cycle
      if (do_retire)
        head <= head + 1'b1;
      count <= count + CNT_W'(rob_alloc.valid) - CNT_W'(do_retire);
    end
  end

endmodule

//--- design/reservation_station.sv
`timescale 1ns/1ps

module reservation_station import ooo_cfg_pkg::*; import ooo_types_pkg::*; #(
  parameter int rs_depth = 4,
  parameter bit unit_id  = 1'b0
) (
  input  logic      run,
  input  logic      arst_n,
  input  dispatch_t disp,
  input  logic      disp_we,
  output logic      full,
  input  cdb_t      cdb,
  output logic      rs_valid,
  output issue_op_t rs_op,
  input  logic      rs_ready
);

  localparam int IDX_W = (rs_depth > 1) ? $clog2(rs_depth) : 1;

  dispatch_t           ent [rs_depth];
  logic [rs_depth-1:0] busy;
  logic [rs_depth-1:0] ready_vec;  // busy with both operands known
  logic [IDX_W-1:0]    free_idx;
  logic [IDX_W-1:0]    sel_idx;
  logic                do_write;
  logic                take;

  // capture a broadcast result for an operand still waiting on its tag
  function automatic operand_t wake(input operand_t op, input cdb_t bus);
    if (!op.known && bus.valid && op.data[TAG_W-1:0] == bus.tag)
    begin
      op.known = 1'b1;
      op.data  = bus.value;
    end
    return op;
  endfunction

  always_comb
  begin
    free_idx = '0;
    sel_idx  = '0;
    // walk down so the lowest index wins
    for (int i = rs_depth - 1; i >= 0; i--)
    begin
      ready_vec[i] = busy[i] && ent[i].src1.known && ent[i].src2.known;
      if (!busy[i])
        free_idx = IDX_W'(i);
      if (ready_vec[i])
        sel_idx = IDX_W'(i);
    end
  end

  assign full     = &busy;
  assign do_write = disp_we && !full;
  assign rs_valid = |ready_vec;
  assign take     = rs_valid && rs_ready;

  assign rs_op.tag    = ent[sel_idx].tag;
  assign rs_op.opcode = ent[sel_idx].opcode;
  assign rs_op.src1   = ent[sel_idx].src1.data;
  assign rs_op.src2   = ent[sel_idx].src2.data;
  assign rs_op.unit   = unit_id;

  always_ff @(posedge run)
  begin
    for (int i = 0; i < rs_depth; i++)
    begin
      if (do_write && free_idx == IDX_W'(i))
        ent[i] <= disp;
      else
      begin
        ent[i].src1 <= wake(ent[i].src1, cdb);
        ent[i].src2 <= wake(ent[i].src2, cdb);
      end
    end
  end

  always_ff @(posedge run or negedge arst_n)
  begin
    if (!arst_n)
      busy <= '0;
    else
    begin
      if (take)
        busy[sel_idx] <= 1'b0;  // freed once the selector has it
      if (do_write)
        busy[free_idx] <= 1'b1;
    end
  end

endmodule

//--- design/issue_select.sv
`timescale 1ns/1ps

module issue_select import ooo_cfg_pkg::*; import ooo_types_pkg::*; (
  input  logic      run,
  input  logic      arst_n,
  input  logic      rs_a_valid,
  input  logic      rs_b_valid,
  input  issue_op_t rs_a_op,
  input  issue_op_t rs_b_op,
  output logic      rs_a_ready,
  output logic      rs_b_ready,
  output logic      issue_valid,
  output issue_op_t issue,
  input  logic      issue_ready
);

  logic load;      // output register empty or draining
  logic grant_a;
  logic grant_b;
  logic prefer_b;  // round-robin pointer

  assign load       = !issue_valid || issue_ready;
  assign grant_a    = rs_a_valid && (!rs_b_valid || !prefer_b);
  assign grant_b    = rs_b_valid && !grant_a;
  assign rs_a_ready = load && grant_a;
  assign rs_b_ready = load && grant_b;

  always_ff @(posedge run)
  begin
    if (load && (grant_a || grant_b))
      issue <= grant_a ? rs_a_op : rs_b_op;
  end

  always_ff @(posedge run or negedge arst_n)
  begin
    if (!arst_n)
    begin
      issue_valid <= 1'b0;
      prefer_b    <= 1'b0;
    end
    else
    begin
      if (load)
        issue_valid <= grant_a || grant_b;
      if (rs_a_ready)
        prefer_b <= 1'b1;  // b goes first next time both offer
      else if (rs_b_ready)
        prefer_b <= 1'b0;
    end
  end

endmodule

//--- design/ooo_issue_top.sv
`timescale 1ns/1ps

module ooo_issue_top import ooo_cfg_pkg::*; import ooo_types_pkg::*; #(
  parameter int iq_depth = IQ_DEPTH_DEF,
  parameter int rs_depth = RS_DEPTH_DEF
) (
  input  logic      run,
  input  logic      arst_n,
  input  logic      instr_valid,
  input  instr_t    instr,
  output logic      instr_ready,
  output logic      issue_valid,
  output issue_op_t issue,
  input  logic      issue_ready,
  input  cdb_t      cdb,
  output retire_t   retire
);

  logic              iq_valid;
  instr_t            iq_instr;
  logic              iq_ready;
  rob_alloc_t        rob_alloc;
  logic [TAG_W-1:0]  alloc_tag;
  logic              rob_full;
  logic [TAG_W-1:0]  rd_tag_a;
  logic [TAG_W-1:0]  rd_tag_b;
  logic              rd_done_a;
  logic              rd_done_b;
  logic [DATA_W-1:0] rd_value_a;
  logic [DATA_W-1:0] rd_value_b;
  dispatch_t         disp;
  logic              disp_a_we;
  logic              disp_b_we;
  logic              rs_a_full;
  logic              rs_b_full;
  logic              rs_a_valid;
  logic              rs_b_valid;
  issue_op_t         rs_a_op;
  issue_op_t         rs_b_op;
  logic              rs_a_ready;
  logic              rs_b_ready;

  instr_queue #(.iq_depth(iq_depth)) instr_queue_i (
    .run, .arst_n, .instr_valid, .instr, .instr_ready,
    .iq_valid, .iq_instr, .iq_ready
  );

  rename_dispatch rename_dispatch_i (
    .run, .arst_n, .iq_valid, .iq_instr, .iq_ready,
    .rob_full, .alloc_tag, .rob_alloc,
    .rd_tag_a, .rd_tag_b, .rd_done_a, .rd_done_b, .rd_value_a, .rd_value_b,
    .rs_a_full, .rs_b_full, .disp, .disp_a_we, .disp_b_we,
    .cdb, .retire
  );

  reorder_buffer reorder_buffer_i (
    .run, .arst_n, .rob_alloc, .alloc_tag, .rob_full,
    .rd_tag_a, .rd_tag_b, .rd_done_a, .rd_done_b, .rd_value_a, .rd_value_b,
    .cdb, .retire
  );

  // station a takes opcodes 0 and 1, station b opcodes 2 and 3
  reservation_station #(.rs_depth(rs_depth), .unit_id(1'b0)) rs_a_i (
    .run, .arst_n, .disp, .disp_we(disp_a_we), .full(rs_a_full), .cdb,
    .rs_valid(rs_a_valid), .rs_op(rs_a_op), .rs_ready(rs_a_ready)
  );

  reservation_station #(.rs_depth(rs_depth), .unit_id(1'b1)) rs_b_i (
    .run, .arst_n, .disp, .disp_we(disp_b_we), .full(rs_b_full), .cdb,
    .rs_valid(rs_b_valid), .rs_op(rs_b_op), .rs_ready(rs_b_ready)
  );

  issue_select issue_select_i (
    .run, .arst_n, .rs_a_valid, .rs_b_valid, .rs_a_op, .rs_b_op,
    .rs_a_ready, .rs_b_ready, .issue_valid, .issue, .issue_ready
  );

endmodule

//--- tests/tb_ooo_issue.sv
`timescale 1ns/1ps

module tb_ooo_issue import ooo_cfg_pkg::*; import ooo_types_pkg::*; ();

  localparam int IQ_DEPTH = 4;
  localparam int RS_DEPTH = 4;
  localparam int MAX_OPS  = 256;

  logic      run = 1'b0;
  logic      arst_n;
  logic      instr_valid;
  instr_t    instr;
  logic      instr_ready;
  logic      issue_valid;
  issue_op_t issue;
  logic      issue_ready;
  cdb_t      cdb;
  retire_t   retire;

  // words waiting to enter the queue with their bias and result delay
  instr_t            send_q[$];
  logic [DATA_W-1:0] bias_q[$];
  int                dly_q[$];

  // reference model indexed by program order of valid opcodes
  logic [OPC_W-1:0]     exp_op   [MAX_OPS];
  logic [DATA_W-1:0]    exp_s1   [MAX_OPS];
  logic [DATA_W-1:0]    exp_s2   [MAX_OPS];
  logic [REG_IDX_W-1:0] exp_rd   [MAX_OPS];
  logic [DATA_W-1:0]    exp_val  [MAX_OPS];
  logic [DATA_W-1:0]    exp_bias [MAX_OPS];
  int                   exp_dly  [MAX_OPS];
  int                   issue_cyc[MAX_OPS];  // -1 until issued
  int                   res_cyc  [MAX_OPS];  // -1 until the result is on the cdb
  int                   res_due  [MAX_OPS];
  logic [DATA_W-1:0]    res_val  [MAX_OPS];
  logic [DATA_W-1:0]    ref_regs [NUM_REGS];
  int                   cyc;
  int                   seq_cnt;
  int                   ret_cnt;
  int                   accepted;
  bit                   rdy_rand;
  logic                 rdy_fixed;

  ooo_issue_top #(.iq_depth(IQ_DEPTH), .rs_depth(RS_DEPTH)) ooo_issue_top_i (
    .run, .arst_n, .instr_valid, .instr, .instr_ready,
    .issue_valid, .issue, .issue_ready, .cdb, .retire
  );

  always #4 run = ~run;

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "stopped at the first error");
  endtask

  // execution rule of the external unit
  function automatic logic [DATA_W-1:0] alu(input logic [OPC_W-1:0] op,
                                            input logic [DATA_W-1:0] a,
                                            input logic [DATA_W-1:0] b);
    case (op)
      4'd0: return a + b;
      4'd1: return a - b;
      4'd2: return a ^ b;
      default: return a & b;
    endcase
  endfunction

  task automatic send(input logic [3:0] op, input logic [3:0] rd, input logic [3:0] rs1,
                      input logic [3:0] rs2, input logic [DATA_W-1:0] bias, input int dly);
    send_q.push_back({op, rd, rs1, rs2});
    bias_q.push_back(bias);
    dly_q.push_back(dly);
  endtask

  task automatic check_retire();
    assert (ret_cnt < seq_cnt)
      else report_error("retire reported with no instruction outstanding");
    assert (retire.tag == TAG_W'(ret_cnt))
      else report_error($sformatf("error retire.tag got %h exp %h", retire.tag, TAG_W'(ret_cnt)));
    assert (retire.rd == exp_rd[ret_cnt])
      else report_error($sformatf("error retire.rd got %h exp %h", retire.rd, exp_rd[ret_cnt]));
    assert (retire.value == exp_val[ret_cnt])
      else report_error($sformatf("error retire.value got %h exp %h",
                                  retire.value, exp_val[ret_cnt]));
    ret_cnt++;
  endtask

  task automatic take_issue();
    int s;
    s = ret_cnt + ((int'(issue.tag) - ret_cnt) & (ROB_DEPTH - 1));  // only in-flight owner
    assert (s < seq_cnt && issue_cyc[s] < 0)
      else report_error($sformatf("issue of tag %0d with no waiting instruction", issue.tag));
    assert (issue.opcode == exp_op[s])
      else report_error($sformatf("error issue.opcode got %h exp %h", issue.opcode, exp_op[s]));
    assert (issue.src1 == exp_s1[s])
      else report_error($sformatf("error issue.src1 got %h exp %h", issue.src1, exp_s1[s]));
    assert (issue.src2 == exp_s2[s])
      else report_error($sformatf("error issue.src2 got %h exp %h", issue.src2, exp_s2[s]));
    assert (issue.unit == exp_op[s][1])
      else report_error($sformatf("error issue.unit got %h exp %h", issue.unit, exp_op[s][1]));
    issue_cyc[s] = cyc;
    res_val[s]   = alu(issue.opcode, issue.src1, issue.src2) + exp_bias[s];
    res_due[s]   = cyc + exp_dly[s];
  endtask

  task automatic accept_instr();
    instr_t            i;
    logic [DATA_W-1:0] b;
    int                d;
    int                s;
    i = send_q.pop_front();
    b = bias_q.pop_front();
    d = dly_q.pop_front();
    s = seq_cnt;
    accepted++;
    if (i.opcode < 4)  // other opcodes leave no trace in the model
    begin
      exp_op[s]    = i.opcode;
      exp_s1[s]    = ref_regs[i.rs1];
      exp_s2[s]    = ref_regs[i.rs2];
      exp_rd[s]    = i.rd;
      exp_val[s]   = alu(i.opcode, exp_s1[s], exp_s2[s]) + b;
      exp_bias[s]  = b;
      exp_dly[s]   = d;
      issue_cyc[s] = -1;
      res_cyc[s]   = -1;
      ref_regs[i.rd] = exp_val[s];
      seq_cnt++;
    end
  endtask

  // drive at the falling edge and account for the next rising edge
  task automatic cycle();
    int s;
    bit hit;
    @(negedge run);
    cyc++;
    cdb = '0;
    hit = 1'b0;
    for (s = ret_cnt; s < seq_cnt; s++)
    begin
      if (!hit && issue_cyc[s] >= 0 && res_cyc[s] < 0 && res_due[s] <= cyc)
      begin
        cdb.valid  = 1'b1;
        cdb.tag    = TAG_W'(s);
        cdb.value  = res_val[s];
        res_cyc[s] = cyc;
        hit        = 1'b1;
      end
    end
    issue_ready = rdy_rand ? ($urandom_range(0, 3) != 0) : rdy_fixed;
    instr_valid = (send_q.size() != 0);
    if (instr_valid)
      instr = send_q[0];
    if (retire.valid)
      check_retire();
    if (issue_valid && issue_ready)
      take_issue();
    if (instr_valid && instr_ready)
      accept_instr();
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (send_q.size() != 0 || ret_cnt != seq_cnt)
    begin
      assert (n < 3000) else report_error("timeout waiting for all instructions to retire");
      cycle();
      n++;
    end
  endtask

  task automatic route_by_opcode();
    for (int op = 0; op < 4; op++)
      send(4'(op), 4'(8 + op), 4'(op), 4'd0, '0, 2);
    drain();
  endtask

  task automatic wake_dependent();
    int s0;
    s0 = seq_cnt;
    send(4'd0, 4'd5, 4'd1, 4'd2, 16'h1234, 12);  // slow producer of r5
    send(4'd2, 4'd6, 4'd5, 4'd0, 16'h0000, 1);
    drain();
    assert (res_cyc[s0] < issue_cyc[s0 + 1])
      else report_error("dependent op issued before its producer result was broadcast");
  endtask

  task automatic retire_in_order();
    int s0;
    s0 = seq_cnt;
    send(4'd0, 4'd1, 4'd5, 4'd6, 16'h0101, 12);
    send(4'd1, 4'd2, 4'd5, 4'd0, 16'h0202, 6);
    send(4'd3, 4'd3, 4'd5, 4'd6, 16'h0303, 1);
    drain();
    assert (res_cyc[s0 + 2] < res_cyc[s0 + 1] && res_cyc[s0 + 1] < res_cyc[s0])
      else report_error("results were not completed out of order");
    send(4'd2, 4'd4, 4'd1, 4'd2, 16'h0000, 1);  // r1 and r2 now come from the register file
    drain();
  endtask

  task automatic fill_under_backpressure();
    issue_op_t held;
    bit        have;
    int        a0;
    int        n;
    a0   = accepted;
    have = 1'b0;
    n    = 0;
    rdy_fixed = 1'b0;
    for (int k = 0; k < 12; k++)
      send(4'd0, 4'(k), 4'(k + 1), 4'(k + 2), 16'(k * 3 + 1), 2);
    while (instr_ready)
    begin
      assert (n < 100) else report_error("timeout waiting for instr_ready to drop");
      cycle();
      n++;
      if (issue_valid && !have)
      begin
        held = issue;
        have = 1'b1;
      end
      else if (issue_valid)
        assert (issue == held)
          else report_error($sformatf("error issue got %h exp %h", issue, held));
    end
    assert (accepted - a0 == IQ_DEPTH + RS_DEPTH + 1)
      else report_error($sformatf("error accepted got %h exp %h", accepted - a0,
                                  IQ_DEPTH + RS_DEPTH + 1));
    rdy_fixed = 1'b1;
    drain();
  endtask

  task automatic drop_invalid_opcodes();
    for (int k = 4; k < 16; k++)
    begin
      send(4'(k), 4'd9, 4'd1, 4'd2, 16'hdead, 1);
      if (k % 4 == 3)
        send(4'(k % 4), 4'(k - 4), 4'd5, 4'd1, 16'(k), 3);
    end
    drain();
  endtask

  task automatic run_random_mix();
    logic [3:0] op;
    rdy_rand = 1'b1;
    for (int k = 0; k < 60; k++)
    begin
      op = 4'($urandom_range(0, 5));
      if (op >= 4)
        op = 4'(4 + $urandom_range(0, 11));
      send(op, 4'($urandom_range(0, 15)), 4'($urandom_range(0, 15)),
           4'($urandom_range(0, 15)), 16'($urandom), $urandom_range(1, 8));
    end
    drain();
    rdy_rand = 1'b0;
  endtask

  initial
  begin
    void'($urandom(33951));
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    issue_ready = 1'b0;
    cdb         = '0;
    rdy_rand    = 1'b0;
    rdy_fixed   = 1'b1;
    cyc         = 0;
    seq_cnt     = 0;
    ret_cnt     = 0;
    accepted    = 0;
    for (int r = 0; r < NUM_REGS; r++)
      ref_regs[r] = '0;
    repeat (10) @(negedge run);
    arst_n = 1'b1;
    route_by_opcode();
    wake_dependent();
    retire_in_order();
    fill_under_backpressure();
    drop_invalid_opcodes();
    run_random_mix();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- src.f
design/ooo_cfg_pkg.sv
design/ooo_types_pkg.sv
design/instr_queue.sv
design/rename_dispatch.sv
design/reorder_buffer.sv
design/reservation_station.sv
design/issue_select.sv
design/ooo_issue_top.sv
tests/tb_ooo_issue.sv

//--- Bender.yml
package:
  name: ooo_issue

sources:
  - files:
      - design/ooo_cfg_pkg.sv
      - design/ooo_types_pkg.sv
      - design/instr_queue.sv
      - design/rename_dispatch.sv
      - design/reorder_buffer.sv
      - design/reservation_station.sv
      - design/issue_select.sv
      - design/ooo_issue_top.sv
  - target: simulation
    files:
      - tests/tb_ooo_issue.sv
